//--- rv32i_pkg.sv
// ****************************************
// Shared types for the RV32I execute slice.
// Import into module bodies, scope in ports.
// ****************************************
package rv32i_pkg;

  // Data path width, RV32 only
  localparam int XLEN = 32;

  // Major opcodes
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011
  } opcode_t;

  // Load widths, stores share the encoding
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  // Instruction format overlays
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  // Decoded control
  typedef struct packed {
    aluop_t     alu_op;
    logic [1:0] alu_a_sel;     // 0,1 rs1; 2 PC
    logic [1:0] alu_b_sel;     // 0 I imm; 1 rs2; 2 S imm; 3 U imm
    logic [1:0] w_sel;         // 0 load; 1 link; 2 U imm; 3 ALU
    logic       wen;
    logic       dren;
    logic       dwen;
    logic       branch;
    logic       jump;
    logic       j_sel;         // JAL when set, JALR otherwise
    load_t      load_type;
    branch_t    branch_type;
    logic       imm_shamt_sel;
    logic       halt;
  } ctrl_t;

  // Sign-extended immediates of every format
  typedef struct packed {
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_sb;
    logic [XLEN-1:0] imm_uj;
    logic [XLEN-1:0] imm_u;
  } imm_t;

  typedef struct packed {
    logic            dren;
    logic            dwen;
    logic [XLEN-1:0] addr;
    logic [3:0]      byte_en;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic            wen;
    logic [4:0]      rd;
    logic [XLEN-1:0] wdata;
  } wb_t;

endpackage

//--- control_unit.sv
// ****************************************
// Combinational RV32I instruction decoder.
// Drives register indices, immediates, control.
// ****************************************
`timescale 1ns/1ns

module control_unit (
  input  logic [31:0]       instr_i,
  output logic [4:0]        rs1_o,
  output logic [4:0]        rs2_o,
  output logic [4:0]        rd_o,
  output rv32i_pkg::imm_t   imm_o,
  output rv32i_pkg::ctrl_t  ctrl_o
);
  import rv32i_pkg::*;

  rtype_t     instr_r;
  itype_t     instr_it;
  stype_t     instr_s;
  sbtype_t    instr_sb;
  utype_t     instr_u;
  ujtype_t    instr_uj;
  opcode_t    opcode;
  imm_funct_t ifunct;
  reg_funct_t rfunct;
  logic       is_imm;
  logic       is_reg;
  logic       sr;
  logic       add_sub;

  assign instr_r  = rtype_t'(instr_i);
  assign instr_it = itype_t'(instr_i);
  assign instr_s  = stype_t'(instr_i);
  assign instr_sb = sbtype_t'(instr_i);
  assign instr_u  = utype_t'(instr_i);
  assign instr_uj = ujtype_t'(instr_i);

  assign opcode = instr_r.opcode;
  assign ifunct = imm_funct_t'(instr_it.funct3);
  assign rfunct = reg_funct_t'(instr_r.funct3);
  assign is_imm = (opcode == IMMED);
  assign is_reg = (opcode == REGREG);

  assign rs1_o = instr_r.rs1;
  assign rs2_o = instr_r.rs2;
  assign rd_o  = instr_r.rd;

  // Sign extension from the top instruction bit
  assign imm_o.imm_i  = {{20{instr_it.imm11_00[11]}}, instr_it.imm11_00};
  assign imm_o.imm_s  = {{20{instr_s.imm11_05[6]}}, instr_s.imm11_05, instr_s.imm04_00};
  assign imm_o.imm_sb = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                         instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};
  assign imm_o.imm_uj = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                         instr_uj.imm11, instr_uj.imm10_01, 1'b0};
  assign imm_o.imm_u  = {instr_u.imm31_12, 12'b0};

  assign ctrl_o.imm_shamt_sel = is_imm && (ifunct == SLLI || ifunct == SRI);
  assign ctrl_o.load_type     = load_t'(instr_it.funct3);
  assign ctrl_o.branch_type   = branch_t'(instr_sb.funct3);

  assign ctrl_o.dren   = (opcode == LOAD);
  assign ctrl_o.dwen   = (opcode == STORE);
  assign ctrl_o.branch = (opcode == BRANCH);
  assign ctrl_o.jump   = (opcode == JAL) || (opcode == JALR);
  assign ctrl_o.j_sel  = (opcode == JAL);

  // Only one system encoding is recognised
  assign ctrl_o.halt = (instr_i == 32'h7800d073);

  always_comb begin
    case (opcode)
      IMMED, LOAD, STORE: ctrl_o.alu_a_sel = 2'd1;
      AUIPC:              ctrl_o.alu_a_sel = 2'd2;
      default:            ctrl_o.alu_a_sel = 2'd0;
    endcase
  end

  always_comb begin
    case (opcode)
      REGREG:  ctrl_o.alu_b_sel = 2'd1;
      STORE:   ctrl_o.alu_b_sel = 2'd2;
      AUIPC:   ctrl_o.alu_b_sel = 2'd3;
      default: ctrl_o.alu_b_sel = 2'd0;
    endcase
  end

  always_comb begin
    case (opcode)
      JAL, JALR:             ctrl_o.w_sel = 2'd1;
      LUI:                   ctrl_o.w_sel = 2'd2;
      IMMED, AUIPC, REGREG:  ctrl_o.w_sel = 2'd3;
      default:               ctrl_o.w_sel = 2'd0;
    endcase
  end

  // Unknown opcodes fall to no write
  always_comb begin
    case (opcode)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: ctrl_o.wen = 1'b1;
      default:                                    ctrl_o.wen = 1'b0;
    endcase
  end

  assign sr      = (is_imm && ifunct == SRI) || (is_reg && rfunct == SR);
  assign add_sub = is_reg && rfunct == ADDSUB;

  // Priority order for the ALU operation
  always_comb begin
    if ((is_imm && ifunct == SLLI) || (is_reg && rfunct == SLL))
      ctrl_o.alu_op = ALU_SLL;
    else if (sr && instr_i[30])
      ctrl_o.alu_op = ALU_SRA;
    else if (sr)
      ctrl_o.alu_op = ALU_SRL;
    else if (add_sub && instr_i[30])
      ctrl_o.alu_op = ALU_SUB;
    else if ((is_imm && ifunct == ANDI) || (is_reg && rfunct == AND))
      ctrl_o.alu_op = ALU_AND;
    else if ((is_imm && ifunct == ORI) || (is_reg && rfunct == OR))
      ctrl_o.alu_op = ALU_OR;
    else if ((is_imm && ifunct == XORI) || (is_reg && rfunct == XOR))
      ctrl_o.alu_op = ALU_XOR;
    else if ((is_imm && ifunct == SLTI) || (is_reg && rfunct == SLT))
      ctrl_o.alu_op = ALU_SLT;
    else if ((is_imm && ifunct == SLTIU) || (is_reg && rfunct == SLTU))
      ctrl_o.alu_op = ALU_SLTU;
    else
      ctrl_o.alu_op = ALU_ADD;   // addi, add, address and AUIPC sums
  end

  // Register writes exclude stores and branches across every opcode
  always_comb begin
    assert (!(ctrl_o.wen && (ctrl_o.dwen || ctrl_o.branch)))
      else $error("control_unit: wen with dwen or branch, opcode %h", opcode);
  end

endmodule

//--- reg_file.sv
// ****************************************
// Register file, two async reads, one write.
// ****************************************
`timescale 1ns/1ns

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                          CLK,
  input  logic                          rst_i,
  input  logic [4:0]                    rs1_i,
  input  logic [4:0]                    rs2_i,
  input  rv32i_pkg::wb_t                wb_i,
  output logic [rv32i_pkg::XLEN-1:0]    rdata1_o,
  output logic [rv32i_pkg::XLEN-1:0]    rdata2_o
);
  import rv32i_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            wr_ok;

  // x0 and indices past the array are never written
  assign wr_ok = wb_i.wen && (wb_i.rd != 5'd0) && (int'(wb_i.rd) < NUM_REGS);

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wb_i.rd[IDX_W-1:0]] <= wb_i.wdata;
    end
  end

  assign rdata1_o = (rs1_i != 5'd0 && int'(rs1_i) < NUM_REGS) ?
                    regs[rs1_i[IDX_W-1:0]] : '0;
  assign rdata2_o = (rs2_i != 5'd0 && int'(rs2_i) < NUM_REGS) ?
                    regs[rs2_i[IDX_W-1:0]] : '0;

  // Storage behind x0 stays clear across every cycle
  assert property (@(posedge CLK) disable iff (rst_i) 1'b1 |=> regs[0] == '0)
    else $error("reg_file: register zero holds %h", regs[0]);

endmodule

//--- execute_stage.sv
// ****************************************
// ALU, branch compare, targets, memory request
// and writeback selection for one instruction.
// ****************************************
`timescale 1ns/1ns

module execute_stage (
  input  logic                          instr_valid_i,
  input  logic [rv32i_pkg::XLEN-1:0]    pc_i,
  input  logic [4:0]                    rd_i,
  input  rv32i_pkg::ctrl_t              ctrl_i,
  input  rv32i_pkg::imm_t               imm_i,
  input  logic [rv32i_pkg::XLEN-1:0]    rdata1_i,
  input  logic [rv32i_pkg::XLEN-1:0]    rdata2_i,
  input  logic [rv32i_pkg::XLEN-1:0]    load_data_i,
  output rv32i_pkg::wb_t                wb_o,
  output rv32i_pkg::mem_req_t           mem_req_o,
  output logic                          branch_taken_o,
  output logic [rv32i_pkg::XLEN-1:0]    target_o,
  output logic                          halt_o
);
  import rv32i_pkg::*;

  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] load_ext;
  logic [XLEN-1:0] store_data;
  logic [3:0]      lanes;
  logic [1:0]      offset;
  logic            cmp;
  logic            live;

  // Halt and idle cycles commit nothing
  assign live = instr_valid_i && !ctrl_i.halt;

  assign alu_a = (ctrl_i.alu_a_sel == 2'd2) ? pc_i : rdata1_i;

  always_comb begin
    case (ctrl_i.alu_b_sel)
      2'd1:    alu_b = rdata2_i;
      2'd2:    alu_b = imm_i.imm_s;
      2'd3:    alu_b = imm_i.imm_u;
      default: alu_b = ctrl_i.imm_shamt_sel ? {27'b0, imm_i.imm_i[4:0]} : imm_i.imm_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SUB:  alu_res = alu_a - alu_b;
      ALU_SLL:  alu_res = alu_a << alu_b[4:0];
      ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
      ALU_SRA:  alu_res = $signed(alu_a) >>> alu_b[4:0];
      ALU_AND:  alu_res = alu_a & alu_b;
      ALU_OR:   alu_res = alu_a | alu_b;
      ALU_XOR:  alu_res = alu_a ^ alu_b;
      ALU_SLT:  alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_res = {31'b0, alu_a < alu_b};
      default:  alu_res = alu_a + alu_b;
    endcase
  end

  always_comb begin
    case (ctrl_i.branch_type)
      BEQ:     cmp = (rdata1_i == rdata2_i);
      BNE:     cmp = (rdata1_i != rdata2_i);
      BLT:     cmp = ($signed(rdata1_i) < $signed(rdata2_i));
      BGE:     cmp = ($signed(rdata1_i) >= $signed(rdata2_i));
      BLTU:    cmp = (rdata1_i < rdata2_i);
      BGEU:    cmp = (rdata1_i >= rdata2_i);
      default: cmp = 1'b0;
    endcase
  end

  // JALR clears bit 0, the rest are PC relative
  always_comb begin
    if (ctrl_i.jump && !ctrl_i.j_sel)
      target_o = (rdata1_i + imm_i.imm_i) & ~32'd1;
    else if (ctrl_i.jump)
      target_o = pc_i + imm_i.imm_uj;
    else
      target_o = pc_i + imm_i.imm_sb;
  end

  // Lane table, misaligned halfwords get no lanes
  assign offset = alu_res[1:0];
  always_comb begin
    case (ctrl_i.load_type)
      LB, LBU: lanes = 4'b0001 << offset;
      LH, LHU: lanes = (offset == 2'b00) ? 4'b0011 :
                       (offset == 2'b10) ? 4'b1100 : 4'b0000;
      LW:      lanes = 4'b1111;
      default: lanes = 4'b0000;
    endcase
  end

  assign shifted = load_data_i >> {offset, 3'b000};
  always_comb begin
    case (ctrl_i.load_type)
      LB:      load_ext = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     load_ext = {24'b0, shifted[7:0]};
      LH:      load_ext = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     load_ext = {16'b0, shifted[15:0]};
      default: load_ext = load_data_i;
    endcase
  end

  // Store data repeated across lanes
  always_comb begin
    case (ctrl_i.load_type)
      LB:      store_data = {4{rdata2_i[7:0]}};
      LH:      store_data = {2{rdata2_i[15:0]}};
      default: store_data = rdata2_i;
    endcase
  end

  assign mem_req_o.dren    = live && ctrl_i.dren;
  assign mem_req_o.dwen    = live && ctrl_i.dwen;
  assign mem_req_o.addr    = alu_res;
  assign mem_req_o.byte_en = (mem_req_o.dren || mem_req_o.dwen) ? lanes : 4'b0000;
  assign mem_req_o.wdata   = store_data;

  assign wb_o.wen = live && ctrl_i.wen;
  assign wb_o.rd  = rd_i;
  always_comb begin
    case (ctrl_i.w_sel)
      2'd0:    wb_o.wdata = load_ext;
      2'd1:    wb_o.wdata = pc_i + 32'd4;
      2'd2:    wb_o.wdata = imm_i.imm_u;
      default: wb_o.wdata = alu_res;
    endcase
  end

  assign branch_taken_o = live && ctrl_i.branch && cmp;
  assign halt_o         = instr_valid_i && ctrl_i.halt;

  // Lanes only leave with a valid load or store
  always_comb begin
    assert (mem_req_o.byte_en == 4'b0000 ||
            (instr_valid_i && (ctrl_i.dren || ctrl_i.dwen)))
      else $error("execute_stage: byte_en %b without memory access", mem_req_o.byte_en);
  end

endmodule

//--- rv32i_core_top.sv
// ****************************************
// RV32I execute slice, one instruction per cycle
// ****************************************
`timescale 1ns/1ns

module rv32i_core_top #(
  parameter int NUM_REGS = 32
) (
  input  logic                          CLK,
  input  logic                          rst_i,
  input  logic                          instr_valid_i,
  input  logic [31:0]                   instr_i,
  input  logic [rv32i_pkg::XLEN-1:0]    pc_i,
  input  logic [rv32i_pkg::XLEN-1:0]    load_data_i,
  output rv32i_pkg::wb_t                wb_o,
  output rv32i_pkg::mem_req_t           mem_req_o,
  output logic                          branch_taken_o,
  output logic [rv32i_pkg::XLEN-1:0]    target_o,
  output logic                          halt_o
);
  import rv32i_pkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  imm_t            imm;
  ctrl_t           ctrl;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;

  control_unit u_control_unit (
    .instr_i (instr_i),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd),
    .imm_o   (imm),
    .ctrl_o  (ctrl)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_file (
    .CLK      (CLK),
    .rst_i    (rst_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .wb_i     (wb_o),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  // Writeback feeds back to the register file write port
  execute_stage u_execute_stage (
    .instr_valid_i  (instr_valid_i),
    .pc_i           (pc_i),
    .rd_i           (rd),
    .ctrl_i         (ctrl),
    .imm_i          (imm),
    .rdata1_i       (rdata1),
    .rdata2_i       (rdata2),
    .load_data_i    (load_data_i),
    .wb_o           (wb_o),
    .mem_req_o      (mem_req_o),
    .branch_taken_o (branch_taken_o),
    .target_o       (target_o),
    .halt_o         (halt_o)
  );

endmodule

//--- rv32i_checker.sv
// ****************************************
// Checker for the RV32I execute slice.
// Mirrors the registers, compares every cycle.
// ****************************************
`timescale 1ns/1ns

module rv32i_checker #(
  parameter int NUM_REGS = 32
) (
  input  logic                CLK,
  input  logic                rst_i,
  input  logic                instr_valid_i,
  input  logic [31:0]         instr_i,
  input  logic [31:0]         pc_i,
  input  logic [31:0]         load_data_i,
  input  rv32i_pkg::wb_t      wb_i,
  input  rv32i_pkg::mem_req_t mem_req_i,
  input  logic                branch_taken_i,
  input  logic [31:0]         target_i,
  input  logic                halt_i,
  output int                  check_count_o,
  output int                  error_count_o
);
  import rv32i_pkg::*;

  localparam logic [31:0] HALT_INSTR = 32'h7800d073;

  typedef struct packed {
    wb_t         wb;
    mem_req_t    mem;
    logic        taken;
    logic        has_target;
    logic [31:0] target;
    logic        halt;
  } expect_t;

  logic [31:0] mirror [32];
  expect_t     expected;
  logic        pend_wen = 1'b0;
  logic [4:0]  pend_rd;
  logic [31:0] pend_data;
  int          checks = 0;
  int          errors = 0;

  assign check_count_o = checks;
  assign error_count_o = errors;

  function automatic logic [31:0] read_reg(input logic [4:0] idx);
    if (idx == 5'd0 || int'(idx) >= NUM_REGS)
      return '0;
    return mirror[idx];
  endfunction

  // Bit 30 picks SUB and SRA
  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt)
          return $signed(x) >>> y[4:0];
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] x,
                                       input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // Byte lanes per access width and address offset
  function automatic logic [3:0] lane_mask(input logic [2:0] f3, input logic [1:0] off);
    logic [3:0] m;
    m = 4'b0000;
    case (f3)
      3'b000, 3'b100: m[off] = 1'b1;
      3'b001, 3'b101: begin
        if (!off[0]) begin
          m[off]      = 1'b1;
          m[off + 1'b1] = 1'b1;
        end
      end
      3'b010:         m = 4'b1111;
      default:        m = 4'b0000;
    endcase
    return m;
  endfunction

  function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [31:0] ld,
                                              input logic [1:0] off);
    logic [31:0] s;
    case (off)
      2'd0:    s = ld;
      2'd1:    s = {8'b0, ld[31:8]};
      2'd2:    s = {16'b0, ld[31:16]};
      default: s = {24'b0, ld[31:24]};
    endcase
    case (f3)
      3'b000:  return {{24{s[7]}}, s[7:0]};
      3'b100:  return {24'b0, s[7:0]};
      3'b001:  return {{16{s[15]}}, s[15:0]};
      3'b101:  return {16'b0, s[15:0]};
      default: return ld;
    endcase
  endfunction

  function automatic expect_t predict(input logic [31:0] ins, input logic [31:0] pc,
                                      input logic [31:0] a, input logic [31:0] b,
                                      input logic [31:0] ld);
    expect_t     e;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    e     = '0;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    e.wb.rd = ins[11:7];
    if (ins == HALT_INSTR) begin
      e.halt = 1'b1;
    end else begin
      case (ins[6:0])
        REGREG: begin
          e.wb.wen   = 1'b1;
          e.wb.wdata = alu_result(f3, ins[30], a, b);
        end
        IMMED: begin
          e.wb.wen   = 1'b1;
          e.wb.wdata = alu_result(f3, f3 == 3'b101 && ins[30], a, imm_i);
        end
        LUI: begin
          e.wb.wen   = 1'b1;
          e.wb.wdata = imm_u;
        end
        AUIPC: begin
          e.wb.wen   = 1'b1;
          e.wb.wdata = pc + imm_u;
        end
        JAL, JALR: begin
          e.wb.wen      = 1'b1;
          e.wb.wdata    = pc + 32'd4;
          e.has_target  = 1'b1;
          e.target      = (ins[6:0] == JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
        end
        BRANCH: begin
          e.has_target = 1'b1;
          e.target     = pc + imm_b;
          e.taken      = branch_cond(f3, a, b);
        end
        LOAD: begin
          e.mem.dren    = 1'b1;
          e.mem.addr    = a + imm_i;
          e.mem.byte_en = lane_mask(f3, e.mem.addr[1:0]);
          e.wb.wen      = 1'b1;
          e.wb.wdata    = extend_load(f3, ld, e.mem.addr[1:0]);
        end
        STORE: begin
          e.mem.dwen    = 1'b1;
          e.mem.addr    = a + imm_s;
          e.mem.byte_en = lane_mask(f3, e.mem.addr[1:0]);
          e.mem.wdata   = (f3 == 3'b000) ? {4{b[7:0]}} :
                          (f3 == 3'b001) ? {2{b[15:0]}} : b;
        end
        default: ;
      endcase
    end
    return e;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("** Error: %s expected %h got %h (pc %h instr %h)",
               name, exp_v, act_v, pc_i, instr_i);
    end
  endtask

  task automatic compare(input expect_t e);
    check_word("halt_o", 32'(e.halt), 32'(halt_i));
    check_word("wb_o.wen", 32'(e.wb.wen), 32'(wb_i.wen));
    if (e.wb.wen) begin
      check_word("wb_o.rd", 32'(e.wb.rd), 32'(wb_i.rd));
      check_word("wb_o.wdata", e.wb.wdata, wb_i.wdata);
    end
    check_word("mem_req_o.dren", 32'(e.mem.dren), 32'(mem_req_i.dren));
    check_word("mem_req_o.dwen", 32'(e.mem.dwen), 32'(mem_req_i.dwen));
    check_word("mem_req_o.byte_en", 32'(e.mem.byte_en), 32'(mem_req_i.byte_en));
    if (e.mem.dren || e.mem.dwen)
      check_word("mem_req_o.addr", e.mem.addr, mem_req_i.addr);
    if (e.mem.dwen)
      check_word("mem_req_o.wdata", e.mem.wdata, mem_req_i.wdata);
    check_word("branch_taken_o", 32'(e.taken), 32'(branch_taken_i));
    if (e.has_target)
      check_word("target_o", e.target, target_i);
  endtask

  // Outputs settle mid-cycle, so sample on the falling edge
  always @(negedge CLK) begin
    if (rst_i) begin
      pend_wen <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        expected = predict(instr_i, pc_i, read_reg(instr_i[19:15]), read_reg(instr_i[24:20]),
                           load_data_i);
      end else begin
        // Idle cycles commit nothing
        expected = '0;
      end
      compare(expected);
      checks++;
      pend_wen  <= expected.wb.wen;
      pend_rd   <= expected.wb.rd;
      pend_data <= expected.wb.wdata;
    end
  end

  always @(posedge CLK) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        mirror[i] <= '0;
      end
    end else if (pend_wen && pend_rd != 5'd0 && int'(pend_rd) < NUM_REGS) begin
      mirror[pend_rd] <= pend_data;
    end
  end

endmodule

//--- tb_rv32i_core.sv
// ****************************************
// Testbench for the RV32I execute slice.
// Random instruction stream, checked beside UUT.
// ****************************************
`timescale 1ns/1ns

module tb_rv32i_core;
  import rv32i_pkg::*;

  localparam int          NUM_REGS       = 32;
  localparam int          RESET_CYCLES   = 5;
  localparam int          NUM_INSTR      = 400;
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + 50;
  localparam logic [31:0] HALT_INSTR     = 32'h7800d073;

  logic        CLK;
  logic        rst_i;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic [31:0] load_data_i;
  wb_t         wb_o;
  mem_req_t    mem_req_o;
  logic        branch_taken_o;
  logic [31:0] target_o;
  logic        halt_o;
  int          check_count;
  int          error_count;
  int          cycle_count = 0;
  logic [31:0] lfsr_state;

  rv32i_core_top #(
    .NUM_REGS (NUM_REGS)
  ) UUT (
    .CLK            (CLK),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .load_data_i    (load_data_i),
    .wb_o           (wb_o),
    .mem_req_o      (mem_req_o),
    .branch_taken_o (branch_taken_o),
    .target_o       (target_o),
    .halt_o         (halt_o)
  );

  rv32i_checker #(
    .NUM_REGS (NUM_REGS)
  ) u_checker (
    .CLK            (CLK),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .load_data_i    (load_data_i),
    .wb_i           (wb_o),
    .mem_req_i      (mem_req_o),
    .branch_taken_i (branch_taken_o),
    .target_i       (target_o),
    .halt_i         (halt_o),
    .check_count_o  (check_count),
    .error_count_o  (error_count)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Legal encodings only, fields otherwise random
  function automatic logic [31:0] random_instr();
    logic [3:0]  pick;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [19:0] upper;
    logic        alt;
    logic [31:0] word;
    pick  = 4'(take_bits(4));
    rd    = 5'(take_bits(5));
    rs1   = 5'(take_bits(5));
    rs2   = 5'(take_bits(5));
    f3    = 3'(take_bits(3));
    imm   = 12'(take_bits(12));
    upper = 20'(take_bits(20));
    alt   = 1'(take_bits(1));
    case (pick)
      4'd0, 4'd12: begin
        if (f3 == 3'd3 || f3 >= 3'd6)
          f3 = f3 & 3'b101;
        word = {imm, rs1, f3, rd, LOAD};
      end
      4'd1, 4'd13: begin
        f3   = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
        word = {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
      end
      4'd2: begin
        if (f3[2:1] == 2'b01)
          f3 = f3 | 3'b100;
        word = {imm[11:5], rs2, rs1, f3, imm[4:0], BRANCH};
      end
      4'd3:  word = {upper, rd, JAL};
      4'd4:  word = {imm, rs1, 3'b000, rd, JALR};
      4'd5, 4'd6, 4'd14: begin
        if (f3 == 3'b001 || f3 == 3'b101)
          word = {1'b0, alt && f3 == 3'b101, 5'b0, imm[4:0], rs1, f3, rd, IMMED};
        else
          word = {imm, rs1, f3, rd, IMMED};
      end
      4'd9:  word = {upper, rd, LUI};
      4'd10: word = {upper, rd, AUIPC};
      4'd11: word = HALT_INSTR;
      default: begin
        alt  = alt && (f3 == 3'b000 || f3 == 3'b101);
        word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, REGREG};
      end
    endcase
    return word;
  endfunction

  task automatic present(input logic valid, input logic [31:0] instr);
    @(posedge CLK);
    instr_valid_i <= valid;
    instr_i       <= instr;
    pc_i          <= take_bits(30) << 2;
    load_data_i   <= take_bits(32);
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    logic [31:0] word;
    logic        valid;
    lfsr_state    = 32'h4656;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    load_data_i   = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_i <= 1'b0;

    // Reset values, an idle write, a write to x0, then halt
    present(1'b1, {7'b0, 5'd7, 5'd3, 3'b000, 5'd5, REGREG});
    present(1'b0, {12'h123, 5'd0, 3'b000, 5'd6, IMMED});
    present(1'b1, {12'h7ff, 5'd0, 3'b000, 5'd0, IMMED});
    present(1'b1, {7'b0, 5'd0, 5'd6, 3'b000, 5'd8, REGREG});
    present(1'b1, HALT_INSTR);

    for (int n = 5; n < NUM_INSTR; n++) begin
      word  = random_instr();
      valid = (take_bits(3) != 32'd0);
      present(valid, word);
    end
    @(posedge CLK);
    instr_valid_i <= 1'b0;
    repeat (2) @(posedge CLK);

    $display("Checked %0d cycles, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
rv32i_pkg.sv
control_unit.sv
reg_file.sv
execute_stage.sv
rv32i_core_top.sv
rv32i_checker.sv
tb_rv32i_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RV32I execute slice testbench with Verilator
LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_rv32i_core \
    -f filelist.f -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
